/* common/stream_pkg.sv */
// Stream package
// Widths, burst and FIFO sizing, audio constants and the packed structs
// and enums shared by the RTG video and aux audio streaming path

package stream_pkg;

  //////////////////////////////
  // Sizes and constants
  localparam int MEM_AW       = 24;         // Word address width
  localparam int WORD_W       = 16;         // Data word width
  localparam int BURST_LEN    = 8;          // Words per burst
  localparam int FIFO_DEPTH   = 32;         // Words per fetcher FIFO
  localparam int PIXW_W       = 4;          // Pixel width field
  localparam int VBEND_W      = 7;          // Vblank end line count
  localparam int AUD_TICK_DIV = 256;        // Clocks per audio tick
  localparam logic [7:0] AUD_BASE_HI = 8'h6F;  // Audio buffer region

  // Derived widths and typed constants
  localparam int FIFO_AW   = $clog2(FIFO_DEPTH);
  localparam int BURST_CW  = $clog2(BURST_LEN);
  localparam int AUD_DIV_W = $clog2(AUD_TICK_DIV);
  localparam logic [BURST_CW-1:0]  BURST_LAST   = BURST_CW'(BURST_LEN - 1);
  localparam logic [BURST_CW:0]    BURST_WORDS  = (BURST_CW + 1)'(BURST_LEN);
  localparam logic [MEM_AW-1:0]    BURST_STEP   = MEM_AW'(BURST_LEN);
  localparam logic [FIFO_AW:0]     FILL_LIMIT   = (FIFO_AW + 1)'(FIFO_DEPTH - BURST_LEN);
  localparam logic [AUD_DIV_W-1:0] AUD_DIV_LAST = AUD_DIV_W'(AUD_TICK_DIV - 1);

  //////////////////////////////
  // Bundles
  typedef struct packed {
    logic              req;                 // Burst request level
    logic [MEM_AW-1:0] addr;                // First word of burst
  } mem_req_t;

  typedef struct packed {
    logic              fill;                // One word per pulse
    logic [WORD_W-1:0] data;
  } mem_rsp_t;

  typedef struct packed {
    logic              ena;                 // RTG screen on
    logic              mode16;              // 16-bit vs 15-bit colour
    logic [PIXW_W-1:0] pixel_width;         // Clocks per pixel minus one
    logic [MEM_AW-1:0] base_addr;           // Frame start
  } rtg_cfg_t;

  typedef struct packed {
    logic hsync;
    logic hblank;
    logic vblank;
  } vid_sync_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef struct packed {
    logic strobe;                           // New pixel this cycle
    rgb_t rgb;
  } vid_out_t;

  //////////////////////////////
  // States
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_VIDEO,
    ARB_AUDIO
  } arb_state_e;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT
  } fetch_state_e;

endpackage

/* design/arbiter/mem_arbiter.sv */
// Memory port arbiter
// Hands the shared SDRAM request/fill port to one stream fetcher per
// burst, video first, and steers the fill pulses back to that owner

module mem_arbiter (
  input  logic                 clk_114,
  input  logic                 rst_n,
  input  stream_pkg::mem_req_t vid_req,
  input  stream_pkg::mem_req_t aud_req,
  output stream_pkg::mem_rsp_t vid_rsp,
  output stream_pkg::mem_rsp_t aud_rsp,
  output stream_pkg::mem_req_t mem_req,
  input  stream_pkg::mem_rsp_t mem_rsp
);

  stream_pkg::arb_state_e             state;      // Current burst owner
  logic [stream_pkg::BURST_CW-1:0]    fill_cnt;   // Fills seen this burst
  logic                               req_q;      // Request toward memory
  logic [stream_pkg::MEM_AW-1:0]      addr_q;     // Latched burst address

  assign mem_req.req  = req_q;
  assign mem_req.addr = addr_q;

  //////////////////////////////
  // Grant and burst tracking
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      state    <= stream_pkg::ARB_IDLE;
      fill_cnt <= '0;
      req_q    <= 1'b0;
      addr_q   <= '0;
    end else begin
      case (state)
        stream_pkg::ARB_IDLE: begin
          fill_cnt <= '0;
          if (vid_req.req) begin                  // Video has priority
            state  <= stream_pkg::ARB_VIDEO;
            req_q  <= 1'b1;
            addr_q <= vid_req.addr;
          end else if (aud_req.req) begin
            state  <= stream_pkg::ARB_AUDIO;
            req_q  <= 1'b1;
            addr_q <= aud_req.addr;
          end
        end
        default: begin
          if (mem_rsp.fill) begin
            req_q    <= 1'b0;                     // Drop after first fill
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == stream_pkg::BURST_LAST) begin
              state <= stream_pkg::ARB_IDLE;      // Port free next cycle
            end
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // Fill steering
  always_comb begin
    vid_rsp = '0;                                 // Non-owner sees nothing
    aud_rsp = '0;
    if (state == stream_pkg::ARB_VIDEO) begin
      vid_rsp = mem_rsp;
    end
    if (state == stream_pkg::ARB_AUDIO) begin
      aud_rsp = mem_rsp;
    end
  end

endmodule

/* design/stream/stream_fetch.sv */
// Stream fetcher
// Prefetches words from memory in bursts into a circular FIFO and offers
// the head word to a consumer; clearing enable restarts from base_addr

module stream_fetch #(
  parameter bit addr_wrap16 = 1'b0                // Wrap low 16 address bits
) (
  input  logic                            clk_114,
  input  logic                            rst_n,
  input  logic                            enable,
  input  logic [stream_pkg::MEM_AW-1:0]   base_addr,
  output stream_pkg::mem_req_t            req,
  input  stream_pkg::mem_rsp_t            rsp,
  input  logic                            pop,
  output logic [stream_pkg::WORD_W-1:0]   head
);

  logic [stream_pkg::WORD_W-1:0]   buf_mem [stream_pkg::FIFO_DEPTH];  // Word storage
  logic [stream_pkg::FIFO_AW-1:0]  wr_ptr;
  logic [stream_pkg::FIFO_AW-1:0]  rd_ptr;
  logic [stream_pkg::FIFO_AW:0]    count;          // Words held
  logic [stream_pkg::FIFO_AW:0]    used;           // Held plus still due
  logic [stream_pkg::BURST_CW:0]   due;            // Words owed by open burst
  stream_pkg::fetch_state_e        state;
  logic                            flush;          // Drop fills of stale burst
  logic                            req_q;
  logic [stream_pkg::MEM_AW-1:0]   req_addr;
  logic [stream_pkg::MEM_AW-1:0]   next_addr;      // Start of next burst
  logic [stream_pkg::MEM_AW-1:0]   step_addr;
  logic                            wr_en;
  logic                            rd_en;
  logic                            space_ok;

  assign req.req  = req_q;
  assign req.addr = req_addr;
  assign head     = buf_mem[rd_ptr];               // Head visible straight away

  assign wr_en    = rsp.fill & enable & ~flush & (state == stream_pkg::FETCH_WAIT);
  assign rd_en    = pop & enable & (count != '0);  // Empty pop ignored
  assign used     = count + {{(stream_pkg::FIFO_AW - stream_pkg::BURST_CW){1'b0}}, due};
  assign space_ok = (used <= stream_pkg::FILL_LIMIT);

  // Next burst address, optionally wrapping inside a 64K word window
  assign step_addr = addr_wrap16 ?
    {next_addr[stream_pkg::MEM_AW-1:16], next_addr[15:0] + stream_pkg::BURST_STEP[15:0]} :
    next_addr + stream_pkg::BURST_STEP;

  //////////////////////////////
  // FIFO storage and pointers
  always_ff @(posedge clk_114) begin
    if (wr_en) begin
      buf_mem[wr_ptr] <= rsp.data;
    end
  end

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (!enable) begin                    // Flush the stream
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (!wr_en && rd_en) begin
        count <= count - 1'b1;
      end
    end
  end

  //////////////////////////////
  // Burst request FSM
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= stream_pkg::FETCH_IDLE;
      req_q     <= 1'b0;
      req_addr  <= '0;
      next_addr <= '0;
      due       <= '0;
      flush     <= 1'b0;
    end else begin
      if (!enable) begin
        next_addr <= base_addr;                    // Restart point
      end
      case (state)
        stream_pkg::FETCH_IDLE: begin
          flush <= 1'b0;
          if (enable && space_ok) begin            // Room for a whole burst
            state     <= stream_pkg::FETCH_WAIT;
            req_q     <= 1'b1;
            req_addr  <= next_addr;
            next_addr <= step_addr;
            due       <= stream_pkg::BURST_WORDS;
          end
        end
        default: begin
          if (!enable) begin
            flush <= 1'b1;                         // Burst still drains
          end
          if (rsp.fill) begin
            req_q <= 1'b0;
            due   <= due - 1'b1;
            if (due == 1) begin
              state <= stream_pkg::FETCH_IDLE;     // Last word of burst
            end
          end
        end
      endcase
    end
  end

endmodule

/* design/video/rtg_video.sv */
// RTG video
// Pixel clock counter, vertical blank line masking from hsync edges,
// pixel fetch strobe and 15/16-bit colour unpacking into a registered
// RGB pixel output

module rtg_video (
  input  logic                             clk_114,
  input  logic                             rst_n,
  input  stream_pkg::rtg_cfg_t             cfg,
  input  logic [stream_pkg::VBEND_W-1:0]   vbend,
  input  stream_pkg::vid_sync_t            sync,
  input  logic [stream_pkg::WORD_W-1:0]    head,
  output logic                             pop,
  output logic                             fetch_enable,
  output stream_pkg::vid_out_t             vid_out
);

  logic [stream_pkg::PIXW_W-1:0]   pix_ctr;        // Compared against pixel_width
  logic                            vb_mask;        // Lines still hidden after vblank
  logic [stream_pkg::VBEND_W-1:0]  vb_ctr;         // Hsync edges since vblank
  logic                            hsync_d;
  logic                            blank;
  logic                            pixel;          // Fetch strobe
  stream_pkg::rgb_t                rgb_dec;        // Unpacked head word
  logic                            strobe_q;
  stream_pkg::rgb_t                rgb_q;

  assign blank        = vb_mask | sync.hblank;
  assign pixel        = cfg.ena & ~blank & (pix_ctr == cfg.pixel_width);
  assign pop          = pixel;                     // One word per pixel
  assign fetch_enable = cfg.ena & ~sync.vblank;    // Stream restarts each frame

  assign vid_out.strobe = strobe_q;
  assign vid_out.rgb    = rgb_q;

  //////////////////////////////
  // Pixel clock counter
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      pix_ctr <= '0;
    end else if (blank || pixel) begin             // Restart per pixel and in blank
      pix_ctr <= '0;
    end else begin
      pix_ctr <= pix_ctr + 1'b1;
    end
  end

  //////////////////////////////
  // Vertical blank mask
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      vb_mask <= 1'b1;
      vb_ctr  <= '0;
      hsync_d <= 1'b0;
    end else begin
      hsync_d <= sync.hsync;
      if (sync.vblank) begin
        vb_mask <= 1'b1;
        vb_ctr  <= '0;
      end else if (vb_ctr == vbend) begin
        vb_mask <= 1'b0;                           // Active lines begin
      end else if (sync.hsync && !hsync_d) begin
        vb_ctr <= vb_ctr + 1'b1;                   // Rising hsync edge
      end
    end
  end

  //////////////////////////////
  // Colour unpacking
  always_comb begin
    if (cfg.mode16) begin                          // RGB565
      rgb_dec.red   = {head[15:11], head[15:13]};
      rgb_dec.green = {head[10:5], head[10:9]};
    end else begin                                 // RGB555
      rgb_dec.red   = {head[14:10], head[14:12]};
      rgb_dec.green = {head[9:5], head[9:7]};
    end
    rgb_dec.blue = {head[4:0], head[4:2]};         // Same in both modes
  end

  // Pixel output, one clock behind the fetch strobe
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      strobe_q <= 1'b0;
      rgb_q    <= '0;
    end else begin
      strobe_q <= pixel;
      if (pixel) begin
        rgb_q <= rgb_dec;                          // Colour of popped word
      end
    end
  end

endmodule

/* design/audio/aux_audio.sv */
// Aux audio
// Divides clk_114 down to a sample tick and pops a left then a right
// sample per tick, byte-swapping each into its output register

module aux_audio (
  input  logic                           clk_114,
  input  logic                           rst_n,
  input  logic                           ena,
  input  logic [stream_pkg::WORD_W-1:0]  head,
  output logic                           pop,
  output logic [stream_pkg::WORD_W-1:0]  left,
  output logic [stream_pkg::WORD_W-1:0]  right
);

  logic [stream_pkg::AUD_DIV_W-1:0]  div_ctr;      // Tick divider
  logic                              tick;         // Left sample slot
  logic                              tick_d;       // Right sample slot
  logic [stream_pkg::WORD_W-1:0]     swapped;

  assign swapped = {head[7:0], head[15:8]};        // Byte order of the buffer
  assign pop     = ena & (tick | tick_d);          // Two pops per tick

  //////////////////////////////
  // Tick generation
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      div_ctr <= '0;
      tick    <= 1'b0;
      tick_d  <= 1'b0;
    end else if (!ena) begin
      div_ctr <= '0;
      tick    <= 1'b0;
      tick_d  <= 1'b0;
    end else begin
      tick    <= (div_ctr == stream_pkg::AUD_DIV_LAST);
      tick_d  <= tick;
      div_ctr <= (div_ctr == stream_pkg::AUD_DIV_LAST) ? '0 : div_ctr + 1'b1;
    end
  end

  //////////////////////////////
  // Sample registers
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      left  <= '0;
      right <= '0;
    end else if (ena) begin                        // Hold while disabled
      if (tick) begin
        left <= swapped;
      end
      if (tick_d) begin
        right <= swapped;
      end
    end
  end

endmodule

/* design/rtg_stream_top.sv */
// RTG stream top
// Video and audio stream fetchers sharing one memory request/fill port
// through the arbiter, feeding the RTG pixel path and the aux audio path

module rtg_stream_top (
  input  logic                            clk_114,
  input  logic                            rst_n,
  input  stream_pkg::rtg_cfg_t            rtg_cfg,
  input  logic [stream_pkg::VBEND_W-1:0]  vbend,
  input  stream_pkg::vid_sync_t           vid_sync,
  input  logic                            aud_ena,
  output stream_pkg::mem_req_t            mem_req,
  input  stream_pkg::mem_rsp_t            mem_rsp,
  output stream_pkg::vid_out_t            vid_out,
  output logic [stream_pkg::WORD_W-1:0]   aud_left,
  output logic [stream_pkg::WORD_W-1:0]   aud_right
);

  stream_pkg::mem_req_t              vid_req;      // Video fetcher to arbiter
  stream_pkg::mem_req_t              aud_req;      // Audio fetcher to arbiter
  stream_pkg::mem_rsp_t              vid_rsp;
  stream_pkg::mem_rsp_t              aud_rsp;
  logic [stream_pkg::WORD_W-1:0]     vid_head;
  logic [stream_pkg::WORD_W-1:0]     aud_head;
  logic                              vid_pop;
  logic                              aud_pop;
  logic                              vid_fetch_en; // Low in vblank

  //////////////////////////////
  // Stream fetchers
  stream_fetch #(
    .addr_wrap16 (1'b0)
  ) u_vid_fetch (
    .clk_114   (clk_114),
    .rst_n     (rst_n),
    .enable    (vid_fetch_en),
    .base_addr (rtg_cfg.base_addr),
    .req       (vid_req),
    .rsp       (vid_rsp),
    .pop       (vid_pop),
    .head      (vid_head)
  );

  stream_fetch #(
    .addr_wrap16 (1'b1)                            // Ring buffer in 64K words
  ) u_aud_fetch (
    .clk_114   (clk_114),
    .rst_n     (rst_n),
    .enable    (aud_ena),
    .base_addr ({stream_pkg::AUD_BASE_HI, 16'h0000}),
    .req       (aud_req),
    .rsp       (aud_rsp),
    .pop       (aud_pop),
    .head      (aud_head)
  );

  mem_arbiter u_arbiter (
    .clk_114 (clk_114),
    .rst_n   (rst_n),
    .vid_req (vid_req),
    .aud_req (aud_req),
    .vid_rsp (vid_rsp),
    .aud_rsp (aud_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  //////////////////////////////
  // Consumers
  rtg_video u_video (
    .clk_114      (clk_114),
    .rst_n        (rst_n),
    .cfg          (rtg_cfg),
    .vbend        (vbend),
    .sync         (vid_sync),
    .head         (vid_head),
    .pop          (vid_pop),
    .fetch_enable (vid_fetch_en),
    .vid_out      (vid_out)
  );

  aux_audio u_audio (
    .clk_114 (clk_114),
    .rst_n   (rst_n),
    .ena     (aud_ena),
    .head    (aud_head),
    .pop     (aud_pop),
    .left    (aud_left),
    .right   (aud_right)
  );

endmodule

/* verif/rtg_stream_props.sv */
// Arbiter properties
// Fill routing and request hold rules of the shared memory port

module rtg_stream_props (
  input logic                   clk_114,
  input logic                   rst_n,
  input stream_pkg::arb_state_e state,
  input stream_pkg::mem_req_t   mem_req,
  input stream_pkg::mem_rsp_t   mem_rsp,
  input stream_pkg::mem_rsp_t   vid_rsp,
  input stream_pkg::mem_rsp_t   aud_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  // Each fill reaches exactly one fetcher, none otherwise
  a_one_owner: assert property (@(posedge clk_114) disable iff (!rst_n)
    mem_rsp.fill ? (vid_rsp.fill ^ aud_rsp.fill) : !(vid_rsp.fill || aud_rsp.fill))
    else $error("fill lost or routed to both fetchers");

  // Request and address held until the first fill
  a_req_hold: assert property (@(posedge clk_114) disable iff (!rst_n)
    (mem_req.req && !mem_rsp.fill) |=> (mem_req.req && $stable(mem_req.addr)))
    else $error("request dropped or moved before first fill");

  // Burst count ends exactly with the last fill
  a_idle_quiet: assert property (@(posedge clk_114) disable iff (!rst_n)
    (state == stream_pkg::ARB_IDLE) |-> !mem_rsp.fill)
    else $error("fill arrived while idle");

endmodule

bind mem_arbiter rtg_stream_props u_props (
  .clk_114 (clk_114),
  .rst_n   (rst_n),
  .state   (state),
  .mem_req (mem_req),
  .mem_rsp (mem_rsp),
  .vid_rsp (vid_rsp),
  .aud_rsp (aud_rsp)
);

/* verif/tb_rtg_stream.sv */
// RTG stream testbench
// Random frame timing, a random-latency burst memory and reference
// models for the pixel colours, audio samples and request addresses

module tb_rtg_stream;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [15:0] WORD_KEY   = 16'h5A3C;   // Memory fill pattern key
  localparam int          AUD_MIN    = 64;         // Samples before the end
  localparam int          WAIT_LIMIT = 4000;       // Cycles for the audio wait

  logic                                clk_114 = 1'b0;
  logic                                rst_n;
  stream_pkg::rtg_cfg_t                rtg_cfg;
  logic [stream_pkg::VBEND_W-1:0]      vbend;
  stream_pkg::vid_sync_t               vid_sync;
  logic                                aud_ena;
  stream_pkg::mem_req_t                mem_req;
  stream_pkg::mem_rsp_t                mem_rsp = '0;
  stream_pkg::vid_out_t                vid_out;
  logic [stream_pkg::WORD_W-1:0]       aud_left;
  logic [stream_pkg::WORD_W-1:0]       aud_right;

  // Memory model
  logic                                mem_busy = 1'b0;
  int                                  mem_gap  = 0;   // Cycles to next fill
  int                                  mem_left = 0;   // Fills still owed
  logic [stream_pkg::MEM_AW-1:0]       mem_addr = '0;
  logic [stream_pkg::MEM_AW-1:0]       exp_vid_req = '0;
  logic [stream_pkg::MEM_AW-1:0]       exp_aud_req = {stream_pkg::AUD_BASE_HI, 16'h0000};
  int                                  base_frame = 0; // Frame of last base burst

  // Monitor state
  int                                  cyc = 0;
  int                                  frame_no = 0;
  int                                  vid_cnt = 0;    // Pixels seen
  int                                  exp_total = 0;  // Pixels expected
  logic [stream_pkg::MEM_AW-1:0]       vid_disp_addr = '0;
  logic [stream_pkg::MEM_AW-1:0]       base_seen = '0;
  logic [15:0]                         aud_idx = '0;   // Sample index in the ring
  int                                  aud_cnt = 0;
  int                                  left_cyc = 0;
  logic [stream_pkg::WORD_W-1:0]       prev_left = '0;
  logic [stream_pkg::WORD_W-1:0]       prev_right = '0;
  logic                                prev_hblank = 1'b1;
  logic                                prev_hsync = 1'b0;
  logic                                prev_vblank = 1'b0;
  int                                  line_id = 0;
  int                                  prev_line = 0;
  int                                  last_line = -1;
  int                                  last_cyc = 0;
  int                                  hs_cnt = 0;     // Hsync edges since vblank
  int                                  prev_hs_cnt = 0;

  rtg_stream_top UUT (
    .clk_114   (clk_114),
    .rst_n     (rst_n),
    .rtg_cfg   (rtg_cfg),
    .vbend     (vbend),
    .vid_sync  (vid_sync),
    .aud_ena   (aud_ena),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .vid_out   (vid_out),
    .aud_left  (aud_left),
    .aud_right (aud_right)
  );

  always #2 clk_114 = ~clk_114;                    // 4 ns period

  //////////////////////////////
  // Helpers
  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic hold(input int n);
    repeat (n) @(posedge clk_114);
    #1;                                            // Drive after the edge
  endtask

  function automatic logic [15:0] word_at(input logic [stream_pkg::MEM_AW-1:0] a);
    return a[15:0] ^ WORD_KEY;
  endfunction

  function automatic logic [15:0] byte_swap(input logic [15:0] w);
    return {w[7:0], w[15:8]};
  endfunction

  // Widen an n-bit channel to 8 bits by repeating its top bits
  function automatic logic [7:0] expand(input logic [7:0] c, input int n);
    return (c << (8 - n)) | (c >> (2 * n - 8));
  endfunction

  function automatic stream_pkg::rgb_t expect_rgb(input logic [15:0] w, input logic m16);
    stream_pkg::rgb_t r;
    if (m16) begin
      r.red   = expand(8'(w[15:11]), 5);
      r.green = expand(8'(w[10:5]), 6);
    end else begin
      r.red   = expand(8'(w[14:10]), 5);
      r.green = expand(8'(w[9:5]), 5);
    end
    r.blue = expand(8'(w[4:0]), 5);
    return r;
  endfunction

  //////////////////////////////
  // Burst memory
  always @(posedge clk_114) begin
    #1;
    mem_rsp.fill = 1'b0;
    if (!mem_busy) begin
      if (mem_req.req) begin
        if (mem_req.addr == exp_aud_req) begin     // Audio ring wraps in 64K
          exp_aud_req = {exp_aud_req[23:16], exp_aud_req[15:0] + 16'd8};
        end else if (mem_req.addr == exp_vid_req) begin
          exp_vid_req = exp_vid_req + 24'd8;
        end else if (base_frame != frame_no && mem_req.addr == base_seen) begin
          exp_vid_req = base_seen + 24'd8;         // New frame from base
          base_frame  = frame_no;
        end else begin
          check(32'(mem_req.addr), 32'(exp_vid_req), "memory request address");
        end
        mem_busy = 1'b1;
        mem_addr = mem_req.addr;
        mem_left = stream_pkg::BURST_LEN;
        mem_gap  = $urandom_range(10, 0);          // Latency 1 to 11
      end
    end else if (mem_gap > 0) begin
      mem_gap = mem_gap - 1;
    end else begin
      mem_rsp.fill = 1'b1;
      mem_rsp.data = word_at(mem_addr);
      mem_addr     = mem_addr + 24'd1;
      mem_left     = mem_left - 1;
      mem_gap      = $urandom_range(1, 0);         // Random fill gaps
      if (mem_left == 0) begin
        mem_busy = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Output monitor
  always @(negedge clk_114) begin
    cyc = cyc + 1;
    if (rst_n) begin
      if (vid_out.strobe) begin                    // Pixel fired last cycle
        check(32'(prev_hblank), 32'd0, "pixel during hblank");
        check(32'(prev_hs_cnt >= int'(vbend)), 32'd1, "pixel in masked line");
        if (prev_line == last_line) begin
          check(32'(cyc - last_cyc), 32'(int'(rtg_cfg.pixel_width) + 1), "pixel spacing");
        end
        check(32'(vid_out.rgb), 32'(expect_rgb(word_at(vid_disp_addr), rtg_cfg.mode16)),
              "pixel colour");
        last_line     = prev_line;
        last_cyc      = cyc;
        vid_disp_addr = vid_disp_addr + 24'd1;
        vid_cnt       = vid_cnt + 1;
      end
      if (aud_left != prev_left) begin
        check(32'(aud_idx[0]), 32'd0, "left sample slot");
        if (aud_cnt > 0) begin                     // One tick per divider period
          check(32'(cyc - left_cyc), 32'(stream_pkg::AUD_TICK_DIV), "audio tick period");
        end
        check(32'(aud_left), 32'(byte_swap(word_at({stream_pkg::AUD_BASE_HI, aud_idx}))),
              "left sample");
        aud_idx  = aud_idx + 16'd1;
        left_cyc = cyc;
        aud_cnt  = aud_cnt + 1;
      end
      if (aud_right != prev_right) begin
        check(32'(aud_idx[0]), 32'd1, "right sample slot");
        check(32'(cyc - left_cyc), 32'd1, "right sample timing");
        check(32'(aud_right), 32'(byte_swap(word_at({stream_pkg::AUD_BASE_HI, aud_idx}))),
              "right sample");
        aud_idx = aud_idx + 16'd1;
        aud_cnt = aud_cnt + 1;
      end
    end
    // Sync tracking
    if (vid_sync.vblank) begin
      vid_disp_addr = rtg_cfg.base_addr;           // Stream restarts
      base_seen     = rtg_cfg.base_addr;
      hs_cnt        = 0;
    end else if (vid_sync.hsync && !prev_hsync) begin
      hs_cnt = hs_cnt + 1;
    end
    if (vid_sync.vblank && !prev_vblank) begin
      frame_no = frame_no + 1;
    end
    if (vid_sync.hblank && !prev_hblank) begin
      line_id = line_id + 1;
    end
    prev_left   = aud_left;
    prev_right  = aud_right;
    prev_hblank = vid_sync.hblank;
    prev_hsync  = vid_sync.hsync;
    prev_vblank = vid_sync.vblank;
    prev_line   = line_id;
    prev_hs_cnt = hs_cnt;
  end

  //////////////////////////////
  // Frame generator
  task automatic run_frame(input logic screen_on, input logic mode16);
    int                            lines;
    int                            act;
    logic [stream_pkg::PIXW_W-1:0] pw;
    vid_sync = '{hsync: 1'b0, hblank: 1'b1, vblank: 1'b1};
    hold(3);
    check(32'(vid_cnt), 32'(exp_total), "pixels per frame");
    pw                  = stream_pkg::PIXW_W'($urandom_range(7, 3));
    rtg_cfg.ena         = screen_on;               // Config only moves in vblank
    rtg_cfg.mode16      = mode16;
    rtg_cfg.pixel_width = pw;
    rtg_cfg.base_addr   = stream_pkg::MEM_AW'($urandom_range(32'h3F_FF00, 0));
    vbend               = stream_pkg::VBEND_W'($urandom_range(3, 0));
    hold($urandom_range(40, 30));
    lines = $urandom_range(7, 4);
    for (int i = 1; i <= lines; i++) begin
      vid_sync = '{hsync: 1'b1, hblank: 1'b1, vblank: 1'b0};
      hold(4);
      vid_sync.hsync = 1'b0;
      hold($urandom_range(59, 44));               // Long porch for prefetch
      act = $urandom_range(100, 40);
      vid_sync.hblank = 1'b0;
      hold(act);
      if (screen_on && i >= int'(vbend)) begin
        exp_total = exp_total + act / (int'(pw) + 1);
      end
    end
    vid_sync.hblank = 1'b1;
    hold(4);
  endtask

  initial begin
    int rnd;
    int wait_cnt;
    rnd      = $urandom(93384);
    rst_n    = 1'b0;
    rtg_cfg  = '0;
    vbend    = '0;
    vid_sync = '{hsync: 1'b0, hblank: 1'b1, vblank: 1'b1};
    aud_ena  = 1'b0;
    hold(3);
    rst_n = 1'b1;
    for (int i = 0; i < 16; i++) begin             // Quiet after reset
      hold(1);
      check(32'(mem_req.req), 32'd0, "request after reset");
      check(32'(vid_out.strobe), 32'd0, "pixel after reset");
      check(32'(vid_out.rgb), 32'd0, "colour after reset");
      check(32'(aud_left), 32'd0, "left after reset");
      check(32'(aud_right), 32'd0, "right after reset");
    end
    for (int f = 0; f < 10; f++) begin
      if (f == 1) begin
        aud_ena = 1'b1;
      end
      run_frame(f != 4, f[0]);                     // Frame 4 has the screen off
    end
    vid_sync = '{hsync: 1'b0, hblank: 1'b1, vblank: 1'b1};
    hold(3);
    check(32'(vid_cnt), 32'(exp_total), "pixels per frame");
    wait_cnt = 0;
    while (aud_cnt < AUD_MIN && wait_cnt < WAIT_LIMIT) begin
      hold(1);
      wait_cnt = wait_cnt + 1;
    end
    if (aud_cnt < AUD_MIN) begin
      stop_on_error("Timed out waiting for audio samples");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* project.f */
common/stream_pkg.sv
design/arbiter/mem_arbiter.sv
design/stream/stream_fetch.sv
design/video/rtg_video.sv
design/audio/aux_audio.sv
design/rtg_stream_top.sv
verif/rtg_stream_props.sv
verif/tb_rtg_stream.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and search the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_rtg_stream \
  -f project.f \
  -o Vtb_rtg_stream
./obj_dir/Vtb_rtg_stream | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  echo "Run passed"
else
  echo "Run failed"
  exit 1
fi
